//--- flist.f
+incdir+hw
hw/cache_pkg.sv
hw/cache_way.sv
hw/line_blender.sv
hw/cache_datapath.sv
hw/cache_ctrl.sv
hw/cache_top.sv
test/pmem_model.sv
test/tb_cache.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= tb_cache
FLIST     ?= flist.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- test/tb_cache.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module tb_cache;
	import cache_pkg::*;

	localparam int PERIOD      = 20;
	localparam int N_DIRECTED  = 16;    // directed ops in the sequence below
	localparam int N_RANDOM    = 300;
	localparam int N_OPS       = N_DIRECTED + N_RANDOM;
	localparam int WATCHDOG_NS = (N_OPS * (4 + 2 * 6) + 100 + 8) * PERIOD;

	logic        clk;
	logic        rst_n;
	cpu_req_t    cpu_req;
	cpu_rsp_t    cpu_rsp;
	logic        credit;
	pmem_req_t   pmem_req;
	pmem_rsp_t   pmem_rsp;
	int          fill_count;
	int          wb_count;
	logic [15:0] last_fill_addr;
	logic [15:0] last_wb_addr;
	logic        wb_bad;

	int          credits = `CACHE_CPU_CREDITS;
	integer      seed    = 32'h156aa415;

	word_t       shadow  [32768];    // expected word per word address
	logic        m_valid [8][2];     // tag state model per set and way
	logic        m_dirty [8][2];
	tag_t        m_tag   [8][2];
	logic        m_lru   [8];

	word_t       exp_word_q [$];     // filled by the driver, drained by the checker
	bit          exp_read_q [$];
	bit          exp_hit_q  [$];
	string       exp_name_q [$];
	time         issue_q    [$];

	cache_top uut (
		.clk      (clk),
		.rst_n    (rst_n),
		.cpu_req  (cpu_req),
		.cpu_rsp  (cpu_rsp),
		.credit   (credit),
		.pmem_req (pmem_req),
		.pmem_rsp (pmem_rsp)
	);

	pmem_model u_pmem (
		.clk            (clk),
		.rst_n          (rst_n),
		.cpu_req        (cpu_req),
		.pmem_req       (pmem_req),
		.pmem_rsp       (pmem_rsp),
		.fill_count     (fill_count),
		.wb_count       (wb_count),
		.last_fill_addr (last_fill_addr),
		.last_wb_addr   (last_wb_addr),
		.wb_bad         (wb_bad)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("tests failed");
		$fatal(1);
	endtask

	// ##########################################################
	// reference model
	// ##########################################################

	function automatic word_t seed_word(input logic [14:0] wa);
		return {wa[6:0], wa[14:7], 1'b0} ^ 16'h3c5a;   // memory content after reset
	endfunction

	function automatic word_t ref_read(input logic [15:0] addr);
		return shadow[addr[15:1]];   // byte bit ignored
	endfunction

	function automatic word_t merge_bytes(input word_t old, input word_t wdata,
			input logic [1:0] be);
		word_t res;
		res = old;
		if (be[0]) res[7:0]  = wdata[7:0];
		if (be[1]) res[15:8] = wdata[15:8];
		return res;
	endfunction

	// tag state, victim choice and LRU as the cache should see them
	task automatic predict(input logic [15:0] addr, input bit write, output bit hit,
			output bit wb, output logic [15:0] wb_addr);
		tag_t   tag;
		index_t idx;
		logic   way;
		tag     = addr[15:7];
		idx     = addr[6:4];
		way     = 1'b0;
		hit     = 1'b0;
		wb      = 1'b0;
		wb_addr = '0;
		for (int w = 0; w < 2; w++) begin
			if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
				hit = 1'b1;
				way = w[0];
			end
		end
		if (!hit) begin
			if (!m_valid[idx][0])      way = 1'b0;
			else if (!m_valid[idx][1]) way = 1'b1;
			else                       way = m_lru[idx];
			wb      = m_dirty[idx][way];   // only a dirty victim goes back
			wb_addr = {m_tag[idx][way], idx, 4'h0};
			m_valid[idx][way] = 1'b1;
			m_tag[idx][way]   = tag;
			m_dirty[idx][way] = 1'b0;
		end
		m_lru[idx] = !way;   // the refill compare counts as a hit too
		if (write) m_dirty[idx][way] = 1'b1;
	endtask

	// ##########################################################
	// driver
	// ##########################################################

	task automatic do_op(input string name, input bit write, input logic [15:0] addr,
			input word_t wdata, input logic [1:0] be);
		bit          hit;
		bit          wb;
		logic [15:0] wb_addr;
		int          fills0;
		int          wbs0;
		cpu_req_t    req;
		predict(addr, write, hit, wb, wb_addr);
		if (write) shadow[addr[15:1]] = merge_bytes(shadow[addr[15:1]], wdata, be);
		@(posedge clk);
		while (credits == 0) @(posedge clk);
		fills0 = fill_count;
		wbs0   = wb_count;
		exp_word_q.push_back(ref_read(addr));
		exp_read_q.push_back(!write);
		exp_hit_q.push_back(hit);
		exp_name_q.push_back(name);
		issue_q.push_back($time);
		req.valid   = 1'b1;
		req.write   = write;
		req.addr    = addr;
		req.wdata   = wdata;
		req.byte_en = be;
		cpu_req <= req;
		credits--;                 // spent on this request
		@(posedge clk);
		cpu_req.valid <= 1'b0;     // valid for one cycle only
		do @(posedge clk); while (!cpu_rsp.valid);
		assert (fill_count - fills0 == (hit ? 0 : 1)) else
			stop_with_error($sformatf("ERROR %s: expected %0d fills, actual %0d",
				name, hit ? 0 : 1, fill_count - fills0));
		assert (wb_count - wbs0 == int'(wb)) else
			stop_with_error($sformatf("ERROR %s: expected %0d writebacks, actual %0d",
				name, wb, wb_count - wbs0));
		if (wb) begin
			assert (last_wb_addr == wb_addr) else
				stop_with_error($sformatf("ERROR %s: expected wb addr %h, actual %h",
					name, wb_addr, last_wb_addr));
		end
		if (!hit) begin
			assert (last_fill_addr == {addr[15:4], 4'h0}) else
				stop_with_error($sformatf("ERROR %s: expected fill addr %h, actual %h",
					name, {addr[15:4], 4'h0}, last_fill_addr));
		end
	endtask

	// ##########################################################
	// response checker
	// ##########################################################

	always @(posedge clk) begin : check_rsp
		string name;
		word_t exp;
		bit    is_read;
		bit    is_hit;
		time   t_issue;
		if (rst_n) begin
			assert (credit == cpu_rsp.valid) else
				stop_with_error($sformatf("ERROR credit: expected %b, actual %b",
					cpu_rsp.valid, credit));
			assert (!wb_bad) else
				stop_with_error("writeback line from the cache differs from the shadow line");
			// each pulse hands back one credit
			if (credit) begin
				credits++;
				assert (credits <= `CACHE_CPU_CREDITS) else
					stop_with_error($sformatf("ERROR credits: expected at most %0d, actual %0d",
						`CACHE_CPU_CREDITS, credits));
			end
			if (cpu_rsp.valid) begin
				assert (exp_name_q.size() > 0) else
					stop_with_error("response arrived with no request outstanding");
				name    = exp_name_q.pop_front();
				exp     = exp_word_q.pop_front();
				is_read = exp_read_q.pop_front();
				is_hit  = exp_hit_q.pop_front();
				t_issue = issue_q.pop_front();
				if (is_read) begin   // write responses carry no data
					assert (cpu_rsp.rdata == exp) else
						stop_with_error($sformatf("ERROR %s: expected %h, actual %h",
							name, exp, cpu_rsp.rdata));
				end
				// sampled at the edge closing cycle 2 after the request cycle
				if (is_hit) begin
					assert ($time - t_issue == 64'(3 * PERIOD)) else
						stop_with_error($sformatf(
							"ERROR %s: expected latency %0d ns, actual %0d ns",
							name, 3 * PERIOD, $time - t_issue));
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		stop_with_error("the run did not finish before the watchdog limit");
	end

	// ##########################################################
	// test sequence
	// ##########################################################

	initial begin : main
		logic [31:0] rnd;
		cpu_req = '0;
		rst_n   = 1'b0;
		for (int i = 0; i < 32768; i++) shadow[i] = seed_word(15'(i));
		for (int s = 0; s < 8; s++) begin
			m_lru[s] = 1'b0;
			for (int w = 0; w < 2; w++) begin
				m_valid[s][w] = 1'b0;
				m_dirty[s][w] = 1'b0;
				m_tag[s][w]   = '0;
			end
		end
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		// quiet after reset
		repeat (4) begin
			@(posedge clk);
			assert (!cpu_rsp.valid && !pmem_req.valid && fill_count == 0) else
				stop_with_error("response or memory request seen right after reset");
		end

		do_op("cold miss", 1'b0, 16'h0100, 16'h0000, 2'b00);
		do_op("read hit", 1'b0, 16'h0100, 16'h0000, 2'b00);
		do_op("read hit", 1'b0, 16'h010e, 16'h0000, 2'b00);

		do_op("byte write", 1'b1, 16'h0104, 16'ha1b2, 2'b01);
		do_op("byte write", 1'b1, 16'h0106, 16'hc3d4, 2'b10);
		do_op("byte write", 1'b1, 16'h0108, 16'he5f6, 2'b11);
		do_op("byte readback", 1'b0, 16'h0104, 16'h0000, 2'b00);
		do_op("byte readback", 1'b0, 16'h0106, 16'h0000, 2'b00);
		do_op("byte readback", 1'b0, 16'h0108, 16'h0000, 2'b00);

		// three tags in set 2
		do_op("eviction", 1'b1, 16'h00a2, 16'h1111, 2'b11);
		do_op("eviction", 1'b1, 16'h0124, 16'h2222, 2'b11);
		do_op("eviction", 1'b0, 16'h01a0, 16'h0000, 2'b00);
		do_op("eviction", 1'b1, 16'h01a6, 16'h3333, 2'b01);
		do_op("eviction", 1'b0, 16'h00a2, 16'h0000, 2'b00);
		do_op("eviction", 1'b0, 16'h0124, 16'h0000, 2'b00);
		do_op("eviction", 1'b0, 16'h01a6, 16'h0000, 2'b00);

		for (int i = 0; i < N_RANDOM; i++) begin
			rnd = $random(seed);
			do_op("random mix", rnd[12], {6'b0, rnd[9:0]}, rnd[31:16], rnd[14:13]);
		end

		repeat (4) @(posedge clk);
		$display("all tests passed");
		$finish;
	end

endmodule

//--- test/pmem_model.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module pmem_model (
	input  logic                  clk,
	input  logic                  rst_n,
	input  cache_pkg::cpu_req_t   cpu_req,        // snooped to keep the shadow current
	input  cache_pkg::pmem_req_t  pmem_req,
	output cache_pkg::pmem_rsp_t  pmem_rsp,
	output int                    fill_count,
	output int                    wb_count,
	output logic [15:0]           last_fill_addr,
	output logic [15:0]           last_wb_addr,
	output logic                  wb_bad          // one cycle pulse, writeback data wrong
);
	import cache_pkg::*;

	line_u       mem    [4096];   // backing store, one entry per line
	line_u       shadow [4096];   // latest processor view of each line
	integer      seed = 32'h156aa415;
	int          wait_q;          // cycles left before ack
	logic        busy;
	logic [11:0] req_line;
	logic [11:0] cpu_line;

	assign req_line = pmem_req.addr[15:4];
	assign cpu_line = cpu_req.addr[15:4];

	// start content depends on every bit of the word address
	function automatic word_t start_word(input logic [14:0] wa);
		return {wa[6:0], wa[14:7], 1'b0} ^ 16'h3c5a;
	endfunction

	// ##########################################################
	// memory, shadow and handshake
	// ##########################################################

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int l = 0; l < 4096; l++) begin
				for (int w = 0; w < 8; w++) begin
					mem[l].words[w]    <= start_word(15'(l * 8 + w));
					shadow[l].words[w] <= start_word(15'(l * 8 + w));
				end
			end
			pmem_rsp       <= '0;
			busy           <= 1'b0;
			wait_q         <= 0;
			fill_count     <= 0;
			wb_count       <= 0;
			last_fill_addr <= '0;
			last_wb_addr   <= '0;
			wb_bad         <= 1'b0;
		end else begin
			pmem_rsp.ack <= 1'b0;   // ack is a single cycle
			wb_bad       <= 1'b0;

			// processor writes go into the shadow right away
			if (cpu_req.valid && cpu_req.write) begin
				if (cpu_req.byte_en[0])
					shadow[cpu_line].bytes[{cpu_req.addr[3:1], 1'b0}] <= cpu_req.wdata[7:0];
				if (cpu_req.byte_en[1])
					shadow[cpu_line].bytes[{cpu_req.addr[3:1], 1'b1}] <= cpu_req.wdata[15:8];
			end

			// skip the ack cycle itself, the next request starts after it
			if (pmem_req.valid && !pmem_rsp.ack) begin
				if (!busy) begin
					busy   <= 1'b1;
					wait_q <= int'($unsigned($random(seed)) % 6);   // 1 to 6 cycles
				end else if (wait_q == 0) begin
					busy         <= 1'b0;
					pmem_rsp.ack <= 1'b1;
					if (pmem_req.write) begin
						mem[req_line] <= pmem_req.data;
						wb_count      <= wb_count + 1;
						last_wb_addr  <= pmem_req.addr;
						wb_bad        <= (pmem_req.data != shadow[req_line]);
					end else begin
						pmem_rsp.data  <= mem[req_line];
						fill_count     <= fill_count + 1;
						last_fill_addr <= pmem_req.addr;
					end
				end else begin
					wait_q <= wait_q - 1;
				end
			end
		end
	end

endmodule

//--- hw/cache_top.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  cache_pkg::cpu_req_t   cpu_req,
	output cache_pkg::cpu_rsp_t   cpu_rsp,
	output logic                  credit,
	output cache_pkg::pmem_req_t  pmem_req,
	input  cache_pkg::pmem_rsp_t  pmem_rsp
);
	import cache_pkg::*;

	dp_ctrl_t                 dp_ctrl;
	dp_status_t               dp_status;
	logic [`CACHE_ADDR_W-1:0] pmem_addr;   // from the datapath
	line_u                    pmem_wdata;
	logic                     pmem_valid;  // from the controller
	logic                     pmem_write;

	// ##########################################################
	// controller
	// ##########################################################

	cache_ctrl u_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.cpu_valid  (cpu_req.valid),
		.status     (dp_status),
		.pmem_ack   (pmem_rsp.ack),
		.ctrl       (dp_ctrl),
		.pmem_valid (pmem_valid),
		.pmem_write (pmem_write),
		.rsp_valid  (cpu_rsp.valid),
		.credit     (credit)
	);

	// ##########################################################
	// datapath
	// ##########################################################

	cache_datapath u_datapath (
		.clk        (clk),
		.rst_n      (rst_n),
		.cpu_req    (cpu_req),
		.ctrl       (dp_ctrl),
		.pmem_rdata (pmem_rsp.data),
		.status     (dp_status),
		.rdata      (cpu_rsp.rdata),
		.pmem_addr  (pmem_addr),
		.pmem_wdata (pmem_wdata)
	);

	// memory request, handshake bits from the controller, payload from the datapath
	assign pmem_req.valid = pmem_valid;
	assign pmem_req.write = pmem_write;
	assign pmem_req.addr  = pmem_addr;
	assign pmem_req.data  = pmem_wdata;

endmodule

//--- hw/cache_ctrl.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_ctrl (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   cpu_valid,   // request present, credit already spent
	input  cache_pkg::dp_status_t  status,
	input  logic                   pmem_ack,
	output cache_pkg::dp_ctrl_t    ctrl,
	output logic                   pmem_valid,
	output logic                   pmem_write,
	output logic                   rsp_valid,
	output logic                   credit       // one pulse per response
);
	import cache_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_COMPARE,    // status valid for the latched request
		ST_RESPOND,
		ST_WRITEBACK,  // dirty victim to memory
		ST_FILL        // line from memory into the victim way
	} state_e;

	state_e                 state_q;
	state_e                 state_d;
	logic [`CACHE_SETS-1:0] lru_q;      // per set, the way to replace next
	logic                   victim_q;   // way chosen on the last miss
	logic                   victim;
	logic                   hit_any;

	assign hit_any = |status.hit;

	// invalid ways first, way 0 before way 1, then the LRU way
	always_comb begin
		if (!status.valid[0]) begin
			victim = 1'b0;
		end else if (!status.valid[1]) begin
			victim = 1'b1;
		end else begin
			victim = lru_q[status.req_index];
		end
	end

	// ##########################################################
	// next state and outputs
	// ##########################################################

	always_comb begin
		state_d       = state_q;
		ctrl          = '0;
		ctrl.wb_way   = victim_q;     // only matters during writeback
		pmem_valid    = 1'b0;
		pmem_write    = 1'b0;
		rsp_valid     = 1'b0;
		credit        = 1'b0;

		case (state_q)
			ST_IDLE: begin
				if (cpu_valid) begin
					ctrl.load_req = 1'b1;
					state_d       = ST_COMPARE;
				end
			end

			ST_COMPARE: begin
				if (hit_any) begin
					// write hit merges the word now, the way updates at the edge
					if (status.req_write) begin
						ctrl.way_we   = status.hit;
						ctrl.dirty_in = 1'b1;
					end
					state_d = ST_RESPOND;
				end else if (status.dirty[victim]) begin
					state_d = ST_WRITEBACK;
				end else begin
					state_d = ST_FILL;
				end
			end

			ST_RESPOND: begin
				rsp_valid = 1'b1;
				credit    = 1'b1;   // credit goes back with the response
				if (cpu_valid) begin
					ctrl.load_req = 1'b1;
					state_d       = ST_COMPARE;
				end else begin
					state_d = ST_IDLE;
				end
			end

			ST_WRITEBACK: begin
				pmem_valid = 1'b1;
				pmem_write = 1'b1;
				if (pmem_ack) begin
					state_d = ST_FILL;
				end
			end

			ST_FILL: begin
				pmem_valid    = 1'b1;
				ctrl.fill_sel = 1'b1;  // held for the whole fill, keeps the address stable
				if (pmem_ack) begin
					ctrl.way_we[victim_q] = 1'b1; // clean line, dirty_in stays 0
					state_d               = ST_COMPARE;  // redo the compare, now a hit
				end
			end

			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	// ##########################################################
	// state, victim and LRU registers
	// ##########################################################

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q  <= ST_IDLE;
			victim_q <= 1'b0;
			lru_q    <= '0;
		end else begin
			state_q <= state_d;
			if (state_q == ST_COMPARE) begin
				if (hit_any) begin
					lru_q[status.req_index] <= status.hit[0]; // point at the way not used
				end else begin
					victim_q <= victim;
				end
			end
		end
	end

endmodule

//--- hw/cache_datapath.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_datapath (
	input  logic                       clk,
	input  logic                       rst_n,
	input  cache_pkg::cpu_req_t        cpu_req,
	input  cache_pkg::dp_ctrl_t        ctrl,
	input  cache_pkg::line_u           pmem_rdata,  // fill line from memory
	output cache_pkg::dp_status_t      status,
	output cache_pkg::word_t           rdata,       // word for the processor
	output logic [`CACHE_ADDR_W-1:0]   pmem_addr,
	output cache_pkg::line_u           pmem_wdata   // victim line for writeback
);
	import cache_pkg::*;

	localparam int LOW_W = `CACHE_ADDR_W - `CACHE_TAG_W - `CACHE_INDEX_W; // offset + byte bit

	cpu_req_t               req_q;        // request under service
	tag_t                   req_tag;
	index_t                 req_index;
	offset_t                req_offset;

	line_u                  way_line [`CACHE_WAYS];
	tag_t                   way_tag  [`CACHE_WAYS];
	logic [`CACHE_WAYS-1:0] way_valid;
	logic [`CACHE_WAYS-1:0] way_dirty;
	logic [`CACHE_WAYS-1:0] way_hit;

	logic                   hit_sel;      // way feeding the read and the blender
	line_u                  hit_line;
	line_u                  blend_line;   // hit line with the write word merged in
	line_u                  line_wr;      // line presented to both ways
	tag_t                   addr_tag;

	// ##########################################################
	// request register and address split
	// ##########################################################

	// loads when the controller accepts a request, holds through the miss
	always_ff @(posedge clk) begin
		if (ctrl.load_req) begin
			req_q <= cpu_req;
		end
	end

	assign req_tag    = req_q.addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
	assign req_index  = req_q.addr[LOW_W +: `CACHE_INDEX_W];
	assign req_offset = req_q.addr[1 +: `CACHE_OFFSET_W];   // bit 0 is the byte bit

	// ##########################################################
	// ways and tag compare
	// ##########################################################

	for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
		cache_way u_way (
			.clk      (clk),
			.rst_n    (rst_n),
			.index    (req_index),
			.we       (ctrl.way_we[w]),
			.line_in  (line_wr),
			.tag_in   (req_tag),            // fill and write hit both store the request tag
			.dirty_in (ctrl.dirty_in),
			.line_out (way_line[w]),
			.tag_out  (way_tag[w]),
			.valid    (way_valid[w]),
			.dirty    (way_dirty[w])
		);

		assign way_hit[w] = way_valid[w] && (way_tag[w] == req_tag);
	end

	// ##########################################################
	// read path, blender and write data
	// ##########################################################

	assign hit_sel  = way_hit[1];            // way 0 when neither hits, value unused then
	assign hit_line = way_line[hit_sel];
	assign rdata    = hit_line.words[req_offset];

	line_blender u_blender (
		.line_in  (hit_line),
		.offset   (req_offset),
		.byte_en  (req_q.byte_en),
		.wdata    (req_q.wdata),
		.line_out (blend_line)
	);

	// memory line on a fill, merged line on a write hit
	assign line_wr = ctrl.fill_sel ? pmem_rdata : blend_line;

	// ##########################################################
	// memory address and writeback data
	// ##########################################################

	// fill_sel also marks the fill phase: request tag, else the victim's stored tag
	assign addr_tag   = ctrl.fill_sel ? req_tag : way_tag[ctrl.wb_way];
	assign pmem_addr  = {addr_tag, req_index, {LOW_W{1'b0}}};  // line aligned
	assign pmem_wdata = way_line[ctrl.wb_way];

	// status back to the controller
	assign status.hit       = way_hit;
	assign status.valid     = way_valid;
	assign status.dirty     = way_dirty;
	assign status.req_write = req_q.write;
	assign status.req_index = req_index;

endmodule

//--- hw/line_blender.sv
`timescale 1ns/1ps

module line_blender (
	input  cache_pkg::line_u   line_in,   // current line contents
	input  cache_pkg::offset_t offset,    // word within the line
	input  logic [1:0]         byte_en,   // [1] high byte, [0] low byte
	input  cache_pkg::word_t   wdata,
	output cache_pkg::line_u   line_out
);

	// byte k of the line sits at bits [8k+7:8k]
	// word n owns bytes 2n (low) and 2n+1 (high)
	always_comb begin
		line_out = line_in; // untouched bytes pass through

		// low byte
		if (byte_en[0]) begin
			line_out.bytes[{offset, 1'b0}] = wdata[7:0];
		end

		// high byte
		if (byte_en[1]) begin
			line_out.bytes[{offset, 1'b1}] = wdata[15:8];
		end
	end

endmodule

//--- hw/cache_way.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_way (
	input  logic               clk,
	input  logic               rst_n,
	input  cache_pkg::index_t  index,     // set being read and written
	input  logic               we,
	input  cache_pkg::line_u   line_in,
	input  cache_pkg::tag_t    tag_in,
	input  logic               dirty_in,
	output cache_pkg::line_u   line_out,
	output cache_pkg::tag_t    tag_out,
	output logic               valid,
	output logic               dirty
);
	import cache_pkg::*;

	// ##########################################################
	// storage
	// ##########################################################

	line_u                  line_q [`CACHE_SETS];  // data array
	tag_t                   tag_q  [`CACHE_SETS];  // tag array
	logic [`CACHE_SETS-1:0] valid_q;               // one valid bit per set
	logic [`CACHE_SETS-1:0] dirty_q;               // one dirty bit per set

	// payload arrays, written whole on every way write
	always_ff @(posedge clk) begin
		if (we) begin
			line_q[index] <= line_in;
			tag_q[index]  <= tag_in;
		end
	end

	// status bits start clear so every set misses after reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (we) begin
			valid_q[index] <= 1'b1;     // any write leaves the entry valid
			dirty_q[index] <= dirty_in; // clean on fill, dirty on write hit
		end
	end

	// ##########################################################
	// combinational read
	// ##########################################################

	assign line_out = line_q[index];
	assign tag_out  = tag_q[index];
	assign valid    = valid_q[index];
	assign dirty    = dirty_q[index];

endmodule

//--- hw/cache_pkg.sv
`include "cache_settings.svh"

package cache_pkg;

	typedef logic [`CACHE_WORD_W-1:0]   word_t;
	typedef logic [`CACHE_TAG_W-1:0]    tag_t;
	typedef logic [`CACHE_INDEX_W-1:0]  index_t;
	typedef logic [`CACHE_OFFSET_W-1:0] offset_t;

	// one cache line, seen as words for reads and writeback, as bytes for the blender
	typedef union packed {
		word_t [`CACHE_LINE_WORDS-1:0]          words;
		logic [`CACHE_LINE_W/8-1:0][7:0]        bytes;
	} line_u;

	typedef struct packed {
		logic                     valid;   // single cycle, spends one credit
		logic                     write;
		logic [`CACHE_ADDR_W-1:0] addr;
		word_t                    wdata;
		logic [1:0]               byte_en; // [1] high byte, [0] low byte
	} cpu_req_t;

	typedef struct packed {
		logic  valid;
		word_t rdata;    // undefined for writes
	} cpu_rsp_t;

	typedef struct packed {
		logic                     valid;
		logic                     write;   // 1 writeback, 0 fill
		logic [`CACHE_ADDR_W-1:0] addr;    // line aligned
		line_u                    data;
	} pmem_req_t;

	typedef struct packed {
		logic  ack;
		line_u data;     // fill data, valid with ack
	} pmem_rsp_t;

	// controller -> datapath
	typedef struct packed {
		logic                   load_req;
		logic [`CACHE_WAYS-1:0] way_we;
		logic                   fill_sel;  // line and address come from the fill path
		logic                   dirty_in;
		logic                   wb_way;
	} dp_ctrl_t;

	// datapath -> controller
	typedef struct packed {
		logic [`CACHE_WAYS-1:0] hit;
		logic [`CACHE_WAYS-1:0] valid;
		logic [`CACHE_WAYS-1:0] dirty;
		logic                   req_write;
		index_t                 req_index;
	} dp_status_t;

endpackage

//--- hw/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// address and data widths
`define CACHE_ADDR_W      16
`define CACHE_WORD_W      16

// address split: tag | index | offset | byte bit
`define CACHE_TAG_W       9
`define CACHE_INDEX_W     3
`define CACHE_OFFSET_W    3

// geometry
`define CACHE_LINE_WORDS  8
`define CACHE_LINE_W      (`CACHE_LINE_WORDS * `CACHE_WORD_W)  // 128 bits per line
`define CACHE_SETS        (1 << `CACHE_INDEX_W)                // one entry per index
`define CACHE_WAYS        2

// processor side flow control
`define CACHE_CPU_CREDITS 1

`endif
